/* design/alu_181.sv */
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 181-style ALU, active-high data. Mode 1 gives the 16 logic
// functions, mode 0 the 16 arithmetic ones plus carry-in.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module alu_181 (
    input  wire  [micro_pkg::DATA_W-1:0] a,
    input  wire  [micro_pkg::DATA_W-1:0] b,
    input  wire  micro_pkg::alu_func_e   func,   // {M, S3..S0}
    input  wire                          cin,    // Adds one in mode 0
    output logic [micro_pkg::DATA_W-1:0] y
);
    import micro_pkg::*;

    logic              mode;
    logic [3:0]        sel;
    logic [DATA_W-1:0] p_term;
    logic [DATA_W-1:0] g_term;

    assign mode = func[FUNC_W-1];
    assign sel  = func[FUNC_W-2:0];

    // Internal propagate and generate as in the original part
    // S0 and S1 pick B or ~B into P, S2 and S3 pick A~B or AB into G
    assign p_term = a
                  | (b  & {DATA_W{sel[0]}})
                  | (~b & {DATA_W{sel[1]}});
    assign g_term = (a & ~b & {DATA_W{sel[2]}})
                  | (a & b  & {DATA_W{sel[3]}});

    always_comb begin
        if (mode) begin
            y = ~(p_term ^ g_term);                  // Logic, no carry chain
        end else begin
            y = p_term + g_term + DATA_W'(cin);      // Arithmetic, wraps mod 256
        end
    end

    // A few sample rows of the table
    //   1001 mode 0   (A|B) + AB    = A plus B
    //   0110 mode 0   (A|~B) + A~B  = A minus B minus 1
    //   1011 mode 1   AB
    //   0110 mode 1   A xor B
    //   1100 mode 1   all ones
    //   0011 mode 1   all zeros

endmodule

`default_nettype wire

/* design/calc_datapath.sv */
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Calculator datapath. Operand muxes, ALU and the F result
// register, steered by the control fields of the microword.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module calc_datapath (
    input  wire                           clk,
    input  wire                           arst_n,
    input  wire  [micro_pkg::UWORD_W-1:0] microword,
    input  wire  [micro_pkg::DATA_W-1:0]  operand_a,
    input  wire  [micro_pkg::DATA_W-1:0]  operand_b,
    output logic [micro_pkg::DATA_W-1:0]  f             // Result register
);
    import micro_pkg::*;

    logic              a_source;
    logic              b_source;
    logic              cin;
    alu_func_e         alu_func;
    alu_dest_e         alu_dest;
    logic [DATA_W-1:0] alu_a;
    logic [DATA_W-1:0] alu_b;
    logic [DATA_W-1:0] alu_y;

    assign a_source = microword[A_SRC_BIT];
    assign b_source = microword[B_SRC_BIT];
    assign cin      = microword[CIN_BIT];
    assign alu_func = alu_func_e'(microword[FUNC_LSB +: FUNC_W]);
    assign alu_dest = alu_dest_e'(microword[DEST_LSB +: DEST_W]);

    assign alu_a = (a_source == SRC_F) ? f : operand_a;   // F feeds ACCUM
    assign alu_b = (b_source == SRC_F) ? f : operand_b;

    alu_181 u_alu_181 (
        .a    (alu_a),
        .b    (alu_b),
        .func (alu_func),
        .cin  (cin),
        .y    (alu_y)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            f <= '0;
        end else if (alu_dest == DEST_F) begin
            f <= alu_y;                                   // Load on F destination
        end
    end

    // Catches bad destination codes from any ROM word
    a_dest_legal: assert property (
        @(posedge clk) disable iff (!arst_n)
        alu_dest inside {DEST_F, DEST_NONE}
    ) else $error("Illegal ALU destination in microword");

endmodule

`default_nettype wire

/* design/control_store.sv */
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Microcode ROM. Combinational lookup of the 24-bit microword
// for the current micro-address, zero latency.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module control_store (
    input  wire  [micro_pkg::UADDR_W-1:0] microaddress,  // From sequencer
    output logic [micro_pkg::UWORD_W-1:0] microword      // To sequencer and datapath
);
    import micro_pkg::*;

    // Packs one microword, count enable always set
    function automatic logic [UWORD_W-1:0] uword(
        input alu_dest_e          dest,
        input alu_func_e          func,
        input logic               cin,
        input logic               a_src,
        input logic               b_src,
        input bop_e               bop,
        input logic [UADDR_W-1:0] addr
    );
        logic [UWORD_W-1:0] w;
        w                          = '0;
        w[DEST_LSB +: DEST_W]      = dest;
        w[CIN_BIT]                 = cin;
        w[FUNC_LSB +: FUNC_W]      = func;
        w[B_SRC_BIT]               = b_src;
        w[A_SRC_BIT]               = a_src;
        w[BOP_LSB +: BOP_W]        = bop;
        w[COUNT_BIT]               = 1'b1;
        w[AD_HI_LSB +: AD_NIB_W]   = addr[UADDR_W-1 -: AD_NIB_W];
        w[AD_LO_LSB +: AD_NIB_W]   = addr[AD_NIB_W-1:0];
        return w;
    endfunction

    always_comb begin
        case (microaddress)
            // Reset flash, F to all ones then jump to 0C
            8'h00: microword = uword(DEST_F, FN_ONES, 1'b0,
                                     SRC_INPUT, SRC_INPUT, BOP_BRANCH, 8'h0C);
            8'h0C: microword = uword(DEST_F, FN_ZERO, 1'b0,     // Flash 00
                                     SRC_INPUT, SRC_INPUT, BOP_COUNT, 8'h00);
            8'h0D: microword = uword(DEST_NONE, FN_ONES, 1'b0,  // Idle until go
                                     SRC_INPUT, SRC_INPUT, BOP_GO_BAR, 8'h0D);
            // Low nibble 1 joins the opcode on dispatch
            8'h0E: microword = uword(DEST_NONE, FN_ONES, 1'b0,
                                     SRC_INPUT, SRC_INPUT, BOP_OPCODE, 8'hF1);

            // Operation words, result to F then wait for release
            {OP_ACCUM, 4'h1}: microword = uword(DEST_F, FN_A_PLUS_B, 1'b0,
                                                SRC_F, SRC_INPUT, BOP_BRANCH, 8'h32);
            {OP_ADD, 4'h1}:   microword = uword(DEST_F, FN_A_PLUS_B, 1'b0,
                                                SRC_INPUT, SRC_INPUT, BOP_BRANCH, 8'h32);
            {OP_SUB, 4'h1}:   microword = uword(DEST_F, FN_A_MINUS_B, 1'b1,
                                                SRC_INPUT, SRC_INPUT, BOP_BRANCH, 8'h32);
            {OP_AND, 4'h1}:   microword = uword(DEST_F, FN_AND, 1'b0,
                                                SRC_INPUT, SRC_INPUT, BOP_BRANCH, 8'h32);
            {OP_XOR, 4'h1}:   microword = uword(DEST_F, FN_XOR, 1'b0,
                                                SRC_INPUT, SRC_INPUT, BOP_BRANCH, 8'h32);

            // Unused opcodes clear F
            8'h01, 8'h21, 8'h41, 8'h51, 8'h61, 8'h81,
            8'h91, 8'hA1, 8'hC1, 8'hD1, 8'hE1:
                microword = uword(DEST_F, FN_ZERO, 1'b0,
                                  SRC_INPUT, SRC_INPUT, BOP_BRANCH, 8'h32);

            8'h32: microword = uword(DEST_NONE, FN_ONES, 1'b0,  // Hold while go high
                                     SRC_INPUT, SRC_INPUT, BOP_NOT_GO_BAR, 8'h32);
            8'h33: microword = uword(DEST_NONE, FN_ONES, 1'b0,  // Back to idle
                                     SRC_INPUT, SRC_INPUT, BOP_BRANCH, 8'h0D);

            // Stray address restarts the microcode
            default: microword = uword(DEST_NONE, FN_ONES, 1'b0,
                                       SRC_INPUT, SRC_INPUT, BOP_BRANCH, 8'h00);
        endcase
    end

endmodule

`default_nettype wire

/* design/micro_calc_top.sv */
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top of the microprogrammed 8-bit calculator. Ties sequencer,
// control store and datapath together.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module micro_calc_top (
    input  wire                            clk,
    input  wire                            arst_n,
    input  wire                            go,          // Level, held per operation
    input  wire  [micro_pkg::OPCODE_W-1:0] opcode,
    input  wire  [micro_pkg::DATA_W-1:0]   operand_a,
    input  wire  [micro_pkg::DATA_W-1:0]   operand_b,
    output logic [micro_pkg::DATA_W-1:0]   f            // Valid 3 cycles after go
);
    import micro_pkg::*;

    logic [UADDR_W-1:0] microaddress;
    logic [UWORD_W-1:0] microword;                      // Fans out to both blocks

    microsequencer u_microsequencer (
        .clk          (clk),
        .arst_n       (arst_n),
        .go           (go),
        .opcode       (opcode_e'(opcode)),
        .microword    (microword),
        .microaddress (microaddress)
    );

    control_store u_control_store (
        .microaddress (microaddress),
        .microword    (microword)
    );

    calc_datapath u_calc_datapath (
        .clk       (clk),
        .arst_n    (arst_n),
        .microword (microword),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .f         (f)
    );

endmodule

`default_nettype wire

/* design/micro_pkg.sv */
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, microword field map and encodings for the
// microprogrammed calculator. Imported by every design block.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package micro_pkg;

    localparam int UADDR_W  = 8;            // Control store depth 256
    localparam int UWORD_W  = 24;           // Microword width
    localparam int DATA_W   = 8;            // Datapath width
    localparam int OPCODE_W = 4;

    localparam int AD_NIB_W = 4;            // Branch address nibble
    localparam int BOP_W    = 4;
    localparam int FUNC_W   = 5;            // Mode bit plus 4 select bits
    localparam int DEST_W   = 3;

    // Microword field positions
    localparam int AD_LO_LSB = 0;           // [3:0]
    localparam int AD_HI_LSB = 4;           // [7:4]
    localparam int COUNT_BIT = 8;           // Count enable
    localparam int BOP_LSB   = 9;           // [12:9]
    localparam int A_SRC_BIT = 13;
    localparam int B_SRC_BIT = 14;
    localparam int FUNC_LSB  = 15;          // [19:15]
    localparam int CIN_BIT   = 20;
    localparam int DEST_LSB  = 21;          // [23:21]

    localparam logic SRC_INPUT = 1'b1;      // Operand from input port
    localparam logic SRC_F     = 1'b0;      // Operand from F register

    typedef enum logic [BOP_W-1:0] {
        BOP_GO_BAR     = 4'b0100,           // Branch if go low
        BOP_COUNT      = 4'b0110,
        BOP_NOT_GO_BAR = 4'b1100,           // Branch if go high
        BOP_BRANCH     = 4'b1110,
        BOP_OPCODE     = 4'b1111            // Dispatch on opcode
    } bop_e;

    typedef enum logic [FUNC_W-1:0] {
        FN_ONES      = 5'b11100,
        FN_ZERO      = 5'b10011,
        FN_A_PLUS_B  = 5'b01001,
        FN_A_MINUS_B = 5'b00110,            // Needs cin 1
        FN_AND       = 5'b11011,
        FN_XOR       = 5'b10110
    } alu_func_e;

    typedef enum logic [DEST_W-1:0] {
        DEST_F    = 3'b011,
        DEST_NONE = 3'b111
    } alu_dest_e;

    typedef enum logic [OPCODE_W-1:0] {
        OP_ACCUM = 4'b0001,                 // F plus B
        OP_ADD   = 4'b0011,
        OP_SUB   = 4'b0111,
        OP_AND   = 4'b1011,
        OP_XOR   = 4'b1111
    } opcode_e;

endpackage

`default_nettype wire

/* design/microsequencer.sv */
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Micro-program counter and next-address logic. Decodes the
// branch op of the current microword, one step per clock.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module microsequencer (
    input  wire                           clk,
    input  wire                           arst_n,
    input  wire                           go,            // Start level
    input  wire  micro_pkg::opcode_e      opcode,        // Dispatch nibble
    input  wire  [micro_pkg::UWORD_W-1:0] microword,
    output logic [micro_pkg::UADDR_W-1:0] microaddress   // Micro-PC
);
    import micro_pkg::*;

    bop_e               bop;
    logic               count_en;
    logic [UADDR_W-1:0] branch_addr;
    logic [UADDR_W-1:0] seq_addr;                         // Count or hold
    logic [UADDR_W-1:0] next_addr;

    assign bop         = bop_e'(microword[BOP_LSB +: BOP_W]);
    assign count_en    = microword[COUNT_BIT];
    assign branch_addr = {microword[AD_HI_LSB +: AD_NIB_W],
                          microword[AD_LO_LSB +: AD_NIB_W]};

    assign seq_addr = count_en ? microaddress + 1'b1 : microaddress;

    always_comb begin
        case (bop)
            BOP_BRANCH:     next_addr = branch_addr;
            BOP_OPCODE:     next_addr = {opcode, branch_addr[AD_NIB_W-1:0]};
            BOP_GO_BAR:     next_addr = go ? seq_addr : branch_addr;  // Loop on low
            BOP_NOT_GO_BAR: next_addr = go ? branch_addr : seq_addr;  // Loop on high
            BOP_COUNT:      next_addr = seq_addr;
            default:        next_addr = seq_addr;                     // Undefined op counts
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            microaddress <= '0;                           // Start of microcode
        end else begin
            microaddress <= next_addr;
        end
    end

    // Dispatch words in the ROM must carry low nibble 1
    a_dispatch_nibble: assert property (
        @(posedge clk) disable iff (!arst_n)
        bop == BOP_OPCODE |=> microaddress[AD_NIB_W-1:0] == 4'h1
    ) else $error("Opcode dispatch landed off an x1 entry point");

    a_reset_start: assert property (
        @(posedge clk) $rose(arst_n) |-> microaddress == '0
    ) else $error("Micro-PC not at 00 after reset");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the calculator testbench with Verilator and runs it.
# Exit status is nonzero when the build, the run or the checks fail.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_micro_calc \
    -f tb.f \
    -Mdir "$BUILD_DIR" -o sim_micro_calc
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_micro_calc" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0

/* tb.f */
design/micro_pkg.sv
design/alu_181.sv
design/control_store.sv
design/microsequencer.sv
design/calc_datapath.sv
design/micro_calc_top.sv
verification/calc_checker.sv
verification/tb_micro_calc.sv

/* verification/calc_checker.sv */
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Watches the calculator ports on the falling clock edge and
// compares F with its own model. Reports each test as it ends.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module calc_checker (
    input  wire       clk,
    input  wire       arst_n,
    input  wire       go,
    input  wire [3:0] opcode,
    input  wire [7:0] operand_a,
    input  wire [7:0] operand_b,
    input  wire [7:0] f,
    output int        tests_done,          // Reset flash counts as test 0
    output int        error_count
);
    int         flash_step;                // 0..2 during reset flash, 3 after
    logic       go_q;
    logic       hold_reported;             // One hold report per result
    logic [3:0] cap_op;
    logic [7:0] cap_a;
    logic [7:0] cap_b;
    logic [7:0] model_f;                   // Expected F, chains for ACCUM
    logic [7:0] want;

    function automatic logic [7:0] expected_f(input logic [3:0] op, input logic [7:0] a,
                                              input logic [7:0] b, input logic [7:0] prev);
        case (op)
            4'b0001: return prev + b;      // ACCUM, A is the old F
            4'b0011: return a + b;
            4'b0111: return a - b;
            4'b1011: return a & b;
            4'b1111: return a ^ b;
            default: return 8'h00;         // Unused codes clear F
        endcase
    endfunction

    always @(negedge clk) begin
        if (!arst_n) begin
            flash_step    = 0;
            go_q          = 1'b0;
            hold_reported = 1'b0;
            model_f       = 8'h00;
            tests_done    = 0;
            error_count   = 0;
        end else if (flash_step < 3) begin
            want = (flash_step == 1) ? 8'hFF : 8'h00;     // 00, FF, 00
            if (f !== want) begin
                $display("ERROR at %0t: reset flash step %0d expected %h got %h",
                         $time, flash_step, want, f);
                error_count++;
            end
            flash_step++;
            if (flash_step == 3) begin
                tests_done++;
                $display("Test 0 reset flash: %0d errors", error_count);
            end
        end else begin
            if (go && !go_q) begin                        // Rising go, take operands
                cap_op = opcode;
                cap_a  = operand_a;
                cap_b  = operand_b;
            end else if (!go && go_q) begin               // Falling go, result due
                want = expected_f(cap_op, cap_a, cap_b, model_f);
                hold_reported = (f !== want);             // Quiet until F matches again
                if (f !== want) begin
                    $display("ERROR at %0t: test %0d opcode %b a %h b %h expected %h got %h",
                             $time, tests_done, cap_op, cap_a, cap_b, want, f);
                    error_count++;
                end else begin
                    $display("Test %0d opcode %b a %h b %h f %h: ok",
                             tests_done, cap_op, cap_a, cap_b, f);
                end
                tests_done++;
                model_f = want;
            end else if (!go && !hold_reported && f !== model_f) begin
                $display("Test %0d: F did not hold its value while go was low", tests_done - 1);
                error_count++;
                hold_reported = 1'b1;
            end
            go_q = go;
        end
    end

endmodule

`default_nettype wire

/* verification/tb_micro_calc.sv */
`timescale 1ns/1ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the microprogrammed calculator. Random ops from
// an LCG drive the DUT, the checker module judges F.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_micro_calc;

    localparam int NUM_TESTS  = 60;
    localparam int WAIT_LIMIT = 200;                   // Cycles per bounded wait
    localparam logic [3:0] VALID_OPS [5]  = '{4'b0001, 4'b0011, 4'b0111, 4'b1011, 4'b1111};
    localparam logic [3:0] SPARE_OPS [11] = '{4'h0, 4'h2, 4'h4, 4'h5, 4'h6, 4'h8,
                                              4'h9, 4'hA, 4'hC, 4'hD, 4'hE};

    logic        clk;
    logic        arst_n;
    logic        go;
    logic [3:0]  opcode;
    logic [7:0]  operand_a;
    logic [7:0]  operand_b;
    wire  [7:0]  f;
    int          tests_done;
    int          error_count;
    logic [31:0] lcg_state;
    logic        timed_out;

    always #20 clk = ~clk;                             // 40 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_for_tests(input int count, input string what);
        int cycles;
        cycles = 0;
        while (tests_done < count && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (tests_done < count) begin
            $display("Timeout: the checker did not finish %s within %0d cycles",
                     what, WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    // One operation: go high 6 cycles, low 3 cycles
    task automatic run_operation();
        logic [3:0] op;
        lcg_state = lcg_next(lcg_state);
        if (lcg_state[31:30] != 2'b11) begin           // Three in four are defined ops
            op = VALID_OPS[int'(lcg_state[29:16]) % 5];
        end else begin
            op = SPARE_OPS[int'(lcg_state[29:16]) % 11];
        end
        @(posedge clk);
        opcode    <= op;
        lcg_state = lcg_next(lcg_state);
        operand_a <= lcg_state[23:16];
        lcg_state = lcg_next(lcg_state);
        operand_b <= lcg_state[23:16];
        go        <= 1'b1;
        wait_cycles(6);
        go <= 1'b0;
        wait_cycles(3);
    endtask

    micro_calc_top u_micro_calc_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .go        (go),
        .opcode    (opcode),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .f         (f)
    );

    calc_checker u_calc_checker (
        .clk         (clk),
        .arst_n      (arst_n),
        .go          (go),
        .opcode      (opcode),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .f           (f),
        .tests_done  (tests_done),
        .error_count (error_count)
    );

    initial begin
        clk       = 1'b0;
        lcg_state = 32'h3102;
        timed_out = 1'b0;
        arst_n    <= 1'b0;
        go        <= 1'b0;
        opcode    <= 4'h0;
        operand_a <= 8'h00;
        operand_b <= 8'h00;
        wait_cycles(2);
        arst_n <= 1'b1;
        wait_for_tests(1, "the reset flash check");
        for (int i = 0; i < NUM_TESTS && !timed_out; i++) begin
            run_operation();
        end
        if (!timed_out) begin
            wait_for_tests(NUM_TESTS + 1, "all operation checks");
        end
        $display("Tests run: %0d, errors: %0d", tests_done, error_count);
        if (timed_out || error_count != 0) begin
            $display("RESULT: FAIL");
        end else begin
            $display("RESULT: PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire
